/* build.f */
hdl/spi_serializer_pkg.sv
hdl/spi_ctrl_fsm.sv
hdl/spi_sclk_gen.sv
hdl/spi_shift_reg.sv
hdl/spi_serializer.sv
tb/spi_ctrl_fsm_sva.sv
tb/tb_spi_serializer.sv

/* hdl/spi_ctrl_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

// transfer controller for the serializer
// it walks idle, load, shift and complete once per word taken from the fifo
// all outputs are decoded from the state register so they change only on clk
module spi_ctrl_fsm
    import spi_serializer_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // fifo is empty, so there is nothing to send
    input  logic      empty,
    // bit counter in the shift register has reached zero
    input  logic      last_bit,
    output spi_ctrl_t ctrl,
    output logic      read_en,
    output logic      done
);

    spi_state_e state_q;
    spi_state_e state_d;

    // state register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // next state logic
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                // the fifo is show-ahead, so a low empty means a word is waiting
                if (!empty) begin
                    state_d = st_load;
                end
            end
            st_load: begin
                // the word is captured at the end of this cycle, always move on
                state_d = st_shift;
            end
            st_shift: begin
                // last_bit rises one cycle after the final decrement
                if (last_bit) begin
                    state_d = st_complete;
                end
            end
            st_complete: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // the pop strobe lines up with the load cycle so the fifo advances
    // on the same edge where the shift register takes read_data
    assign read_en = (state_q == st_load);

    // done is a single pulse because complete always returns to idle
    assign done = (state_q == st_complete);

    always_comb begin
        ctrl.load = (state_q == st_load);
        // the final shift cycle only waits for the state to change
        // so the serial clock is held low there and cannot start a ninth period
        ctrl.shift_phase = (state_q == st_shift) && !last_bit;
    end

endmodule

`default_nettype wire

/* hdl/spi_sclk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// serial clock generator
// a free running divider sets the pace and sclk moves on every falling
// transition of it, so each sclk level lasts two clk cycles
module spi_sclk_gen
    import spi_serializer_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  spi_ctrl_t ctrl,
    output logic      sclk,
    // one cycle pulse in the first clk cycle with sclk low after a fall
    output logic      sclk_fall
);

    logic clk_div;
    logic div_falling;

    // divide by two, runs whether or not a transfer is in progress
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_div <= 1'b0;
        end else begin
            clk_div <= ~clk_div;
        end
    end

    // the divider is high now and drops at the coming edge
    assign div_falling = clk_div;

    // sclk only toggles while shifting
    // between transfers it is forced low and stays there
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk <= 1'b0;
        end else if (!ctrl.shift_phase) begin
            sclk <= 1'b0;
        end else if (div_falling) begin
            sclk <= ~sclk;
        end
    end

    // flag the edge where sclk goes from high to low
    // the shift register uses it to step to the next bit while sclk is low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_fall <= 1'b0;
        end else begin
            sclk_fall <= ctrl.shift_phase && div_falling && sclk;
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

// spi serializer top level
// takes one word from a show-ahead fifo and sends it msb first on mosi
// with sclk idling low, then pulses done
module spi_serializer
    import spi_serializer_pkg::*;
#(
    parameter int DATA_WIDTH = SPI_DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    // fifo side, read_data is valid whenever empty is low
    input  logic                  empty,
    input  logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_en,
    // serial side
    output logic                  sclk,
    output logic                  mosi,
    // one cycle pulse at the end of each word
    output logic                  done
);

    // commands from the controller to both datapath blocks
    spi_ctrl_t ctrl;
    // falling sclk marker that steps the shift register
    logic      sclk_fall;
    // counter has run out
    logic      last_bit;

    // controller
    spi_ctrl_fsm u_ctrl_fsm (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .last_bit (last_bit),
        .ctrl     (ctrl),
        .read_en  (read_en),
        .done     (done)
    );

    // serial clock and its fall marker
    spi_sclk_gen u_sclk_gen (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .sclk      (sclk),
        .sclk_fall (sclk_fall)
    );

    // data path
    // the width is handed down from here so one setting sizes the whole design
    spi_shift_reg #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_shift_reg (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .read_data (read_data),
        .sclk_fall (sclk_fall),
        .mosi      (mosi),
        .last_bit  (last_bit)
    );

endmodule

`default_nettype wire

/* hdl/spi_serializer_pkg.sv */
`default_nettype none

// shared types for the spi serializer
// the controller owns the state and the datapath blocks see only the control struct
package spi_serializer_pkg;

    // word width used when the top level is not overridden
    localparam int SPI_DATA_WIDTH_DEFAULT = 8;

    // controller states in the order they are visited during one transfer
    // idle waits for a word, load pops it, shift sends it, complete flags the end
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_load     = 2'd1,
        st_shift    = 2'd2,
        st_complete = 2'd3
    } spi_state_e;

    // commands from the controller to the serial clock and the shift register
    // load is high for the single load cycle
    // shift_phase is high while bits are still going out on mosi
    typedef struct packed {
        logic load;
        logic shift_phase;
    } spi_ctrl_t;

endpackage

`default_nettype wire

/* hdl/spi_shift_reg.sv */
`timescale 1ns/1ns
`default_nettype none

// parallel to serial shift register with its bit counter
// the word leaves msb first and a new bit appears after every falling sclk
module spi_shift_reg
    import spi_serializer_pkg::*;
#(
    parameter int DATA_WIDTH = SPI_DATA_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  spi_ctrl_t             ctrl,
    input  logic [DATA_WIDTH-1:0] read_data,
    input  logic                  sclk_fall,
    output logic                  mosi,
    output logic                  last_bit
);

    // the counter must hold DATA_WIDTH itself, not just DATA_WIDTH-1
    localparam int CNT_WIDTH = $clog2(DATA_WIDTH + 1);

    logic [DATA_WIDTH-1:0] shift_q;
    logic [CNT_WIDTH-1:0]  bit_cnt_q;
    logic                  step;

    // advance one bit per serial clock period, only while shifting
    assign step = ctrl.shift_phase && sclk_fall;

    // data register
    // zeros enter from the bottom so the word is empty after the last step
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            shift_q <= read_data;
        end else if (step) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // bits still to go out on mosi
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt_q <= '0;
        end else if (ctrl.load) begin
            bit_cnt_q <= CNT_WIDTH'(DATA_WIDTH);
        end else if (step) begin
            bit_cnt_q <= bit_cnt_q - 1'b1;
        end
    end

    // the msb is on the line from the start of shift
    // each bit changes half way through the low sclk level
    // and holds across the next rising edge where the receiver samples it
    assign mosi = ctrl.shift_phase & shift_q[DATA_WIDTH-1];

    // the counter is zero in idle too, the controller only looks at it in shift
    assign last_bit = (bit_cnt_q == '0);

endmodule

`default_nettype wire

/* tb/spi_ctrl_fsm_sva.sv */
`timescale 1ns/1ns
`default_nettype none

// sequencing rules of the transfer controller
// bound into the controller so it sees the state register directly
module spi_ctrl_fsm_sva
    import spi_serializer_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       empty,
    input spi_state_e state,
    input logic       read_en,
    input logic       done
);

    // the word is captured in load, so shifting must start at once
    property load_then_shift;
        @(posedge clk) disable iff (rst)
            (state == st_load) |=> (state == st_shift);
    endproperty

    // complete lasts one cycle and always returns to idle
    property complete_then_idle;
        @(posedge clk) disable iff (rst)
            (state == st_complete) |=> (state == st_idle);
    endproperty

    // the fifo pop strobe belongs to the load state alone
    // and that load is only reached from idle while a word is waiting
    property read_en_only_in_load;
        @(posedge clk) disable iff (rst)
            read_en |-> (state == st_load) && $past(state == st_idle) && $past(!empty);
    endproperty

    // done is a pulse and never a level
    property done_single_cycle;
        @(posedge clk) disable iff (rst)
            done |=> !done;
    endproperty

    a_load_then_shift: assert property (load_then_shift)
        else $error("load was not followed by shift");

    a_complete_then_idle: assert property (complete_then_idle)
        else $error("complete was not followed by idle");

    a_read_en_only_in_load: assert property (read_en_only_in_load)
        else $error("read_en high outside a load entered from idle with a word waiting");

    a_done_single_cycle: assert property (done_single_cycle)
        else $error("done high for two cycles in a row");

endmodule

// every controller instance gets the checker
bind spi_ctrl_fsm spi_ctrl_fsm_sva u_ctrl_fsm_sva (
    .clk     (clk),
    .rst     (rst),
    .empty   (empty),
    .state   (state_q),
    .read_en (read_en),
    .done    (done)
);

`default_nettype wire

/* tb/spi_serializer_vectors.txt */
// columns: data word (hex), idle gap in clk cycles before the word (hex)
// the gap is counted from the done pulse of the word before
A5 03
5A 00
FF 01
00 02
80 00
01 05
C3 00
3C 04
7E 01
81 00
96 07
69 02
F0 00
0F 03
55 01
AA 00

/* tb/tb_spi_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

// testbench for the spi serializer
// a show-ahead fifo model feeds the words of the vectors file to the dut
// every clk cycle is sampled on the falling edge, where the dut outputs are settled,
// and the new fifo inputs are driven right after that sample
module tb_spi_serializer;

    localparam int DATA_WIDTH = 8;
    localparam int MAX_VECS   = 32;

    logic                  clk;
    logic                  rst;
    logic                  empty;
    logic [DATA_WIDTH-1:0] read_data;
    logic                  read_en;
    logic                  sclk;
    logic                  mosi;
    logic                  done;

    // word and gap interleaved, two entries for every line of the file
    logic [7:0] vec_mem [0:2*MAX_VECS-1];
    int num_vecs;
    int cycle_limit;
    int timeout_cnt = 0;

    int value_errors;
    int protocol_errors;

    // monitor state, updated once per sampled cycle
    logic                  prev_sclk;
    logic                  prev_read_en;
    logic                  prev_done;
    int                    level_len;
    int                    rise_count;
    int                    read_en_count;
    int                    done_count;
    logic                  capturing;
    // high while the fifo model holds empty between two words and the dut is idle
    logic                  in_gap;
    logic [DATA_WIDTH-1:0] exp_word;
    logic [DATA_WIDTH-1:0] rx_word;

    spi_serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .read_data (read_data),
        .read_en   (read_en),
        .sclk      (sclk),
        .mosi      (mosi),
        .done      (done)
    );

    // 20 ns clock period
    always #10 clk = ~clk;

    // watchdog, counts rising edges out of reset against the limit from the vectors
    always @(posedge clk) begin
        if (!rst) begin
            timeout_cnt = timeout_cnt + 1;
            if (timeout_cnt > cycle_limit) begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Error counts: value %0d, protocol %0d", value_errors, protocol_errors);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        value_errors++;
        $display("Error: time %0t, %s expected %0h received %0h", $time, name, exp, got);
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("Protocol failure at time %0t: %s", $time, what);
    endtask

    // checks one sampled cycle of the dut outputs
    task automatic sample_cycle();
        logic rise;
        logic fall;
        rise = sclk && !prev_sclk;
        fall = !sclk && prev_sclk;
        // with no word offered the dut must stay quiet
        if (in_gap) begin
            assert (read_en == 1'b0) else report_mismatch("read_en", 0, read_en);
            assert (sclk == 1'b0) else report_mismatch("sclk", 0, sclk);
            assert (mosi == 1'b0) else report_mismatch("mosi", 0, mosi);
        end
        // the pop strobe opens the capture of one word
        if (read_en) begin
            assert (!prev_read_en) else report_protocol("read_en stayed high for two cycles");
            if (!prev_read_en) begin
                read_en_count++;
                assert (!capturing) else report_protocol("read_en came before done");
                capturing  = 1'b1;
                rise_count = 0;
                rx_word    = '0;
            end
        end
        // a receiver samples mosi on the rising sclk edge
        if (rise) begin
            assert (capturing) else report_protocol("sclk rose outside a transfer");
            if (rise_count > 0) begin
                assert (level_len == 2) else report_mismatch("sclk low length", 2, level_len);
            end
            if (rise_count < DATA_WIDTH) begin
                assert (mosi == exp_word[DATA_WIDTH-1-rise_count])
                    else report_mismatch("mosi", exp_word[DATA_WIDTH-1-rise_count], mosi);
            end
            rx_word = {rx_word[DATA_WIDTH-2:0], mosi};
            rise_count++;
        end
        if (fall) begin
            assert (level_len == 2) else report_mismatch("sclk high length", 2, level_len);
        end
        if (sclk != prev_sclk) begin
            level_len = 1;
        end else begin
            level_len++;
        end
        // done closes the word, all bits must be in by now
        if (done) begin
            assert (!prev_done) else report_protocol("done stayed high for two cycles");
            if (!prev_done) begin
                done_count++;
                assert (capturing) else report_protocol("done came without a read_en");
                assert (rise_count == DATA_WIDTH)
                    else report_mismatch("sclk rises", DATA_WIDTH, rise_count);
                assert (rx_word == exp_word) else report_mismatch("mosi word", exp_word, rx_word);
                capturing = 1'b0;
            end
        end
        prev_sclk    = sclk;
        prev_read_en = read_en;
        prev_done    = done;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        sample_cycle();
    endtask

    // fifo model for one word, the gap is counted from the previous done
    task automatic send_word(input logic [DATA_WIDTH-1:0] word, input int gap);
        in_gap = 1'b1;
        repeat (gap) begin
            next_cycle();
        end
        in_gap    = 1'b0;
        exp_word  = word;
        read_data = word;
        empty     = 1'b0;
        next_cycle();
        while (!read_en) begin
            next_cycle();
        end
        // the pop takes effect at the edge that ends the read_en cycle
        next_cycle();
        empty     = 1'b1;
        read_data = ~word;
        while (!done) begin
            next_cycle();
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        empty           = 1'b1;
        read_data       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        prev_sclk       = 1'b0;
        prev_read_en    = 1'b0;
        prev_done       = 1'b0;
        level_len       = 0;
        rise_count      = 0;
        read_en_count   = 0;
        done_count      = 0;
        capturing       = 1'b0;
        in_gap          = 1'b1;
        exp_word        = '0;
        rx_word         = '0;

        // unknown entries mark the end of the file
        for (int i = 0; i < 2 * MAX_VECS; i++) begin
            vec_mem[i] = 'x;
        end
        $readmemh("tb/spi_serializer_vectors.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && !$isunknown(vec_mem[2*num_vecs])
               && !$isunknown(vec_mem[2*num_vecs+1])) begin
            num_vecs++;
        end
        assert (num_vecs > 0) else report_protocol("the vectors file holds no words");

        // each word gets its gap, four clk per bit and some slack
        cycle_limit = 0;
        for (int i = 0; i < num_vecs; i++) begin
            cycle_limit += vec_mem[2*i+1] + 4 * DATA_WIDTH + 16;
        end

        repeat (5) @(negedge clk);
        rst = 1'b0;

        // nothing offered yet, so every output is low
        next_cycle();
        assert (read_en == 1'b0) else report_mismatch("read_en", 0, read_en);
        assert (done == 1'b0) else report_mismatch("done", 0, done);
        assert (sclk == 1'b0) else report_mismatch("sclk", 0, sclk);
        assert (mosi == 1'b0) else report_mismatch("mosi", 0, mosi);

        for (int i = 0; i < num_vecs; i++) begin
            send_word(vec_mem[2*i], vec_mem[2*i+1]);
        end

        in_gap = 1'b1;
        repeat (4) begin
            next_cycle();
        end
        assert (read_en_count == num_vecs) else report_mismatch("read_en pulses", num_vecs,
                                                                read_en_count);
        assert (done_count == num_vecs) else report_mismatch("done pulses", num_vecs, done_count);

        $display("Error counts: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
